//--- Bender.yml
package:
  name: cart_loader

sources:
  - design/cart_pkg.sv
  - design/load_if.sv
  - design/load_ctrl.sv
  - design/region_detect.sv
  - design/cart_quirks.sv
  - design/cheat_loader.sv
  - design/cart_loader_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cart_loader.sv

//--- design/cart_loader_top.sv
module cart_loader_top import cart_pkg::*; #(
	parameter int ADDR_W = cart_pkg::ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic              ioctl_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  word_t             ioctl_data,
	input  logic              auto_region_off,
	input  region_prio_t      region_priority,
	output region_t           region_req,
	output logic              region_set,
	output logic [ADDR_W-1:0] rom_size,
	output eeprom_map_t       eeprom_map,
	output logic              bank_eeprom_quirk,
	output logic              noram_quirk,
	output logic              fmbusy_quirk,
	output logic              gun_type,
	output sensor_delay_t     gun_sensor_delay,
	output gg_code_t          gg_code,
	output logic              gg_valid,
	output logic              gg_clear
);

	region_t region_choice;

	load_if #(.ADDR_W(ADDR_W)) ld_bus ();

	//////////////////////////////////////////////////////////////////////
	load_ctrl #(.ADDR_W(ADDR_W)) u_load_ctrl (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.ioctl_download  (ioctl_download),
		.ioctl_index     (ioctl_index),
		.ioctl_wr        (ioctl_wr),
		.ioctl_addr      (ioctl_addr),
		.ioctl_data      (ioctl_data),
		.auto_region_off (auto_region_off),
		.region_choice   (region_choice),
		.ld              (ld_bus),
		.region_req      (region_req),
		.region_set      (region_set),
		.rom_size        (rom_size)
	);

	region_detect u_region_detect (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.ld              (ld_bus),
		.region_priority (region_priority),
		.region_choice   (region_choice)
	);

	cart_quirks #(.ADDR_W(ADDR_W)) u_cart_quirks (
		.clk_sys           (clk_sys),
		.RESET             (RESET),
		.ld                (ld_bus),
		.eeprom_map        (eeprom_map),
		.bank_eeprom_quirk (bank_eeprom_quirk),
		.noram_quirk       (noram_quirk),
		.fmbusy_quirk      (fmbusy_quirk),
		.gun_type          (gun_type),
		.gun_sensor_delay  (gun_sensor_delay)
	);

	cheat_loader u_cheat_loader (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.ld       (ld_bus),
		.gg_code  (gg_code),
		.gg_valid (gg_valid),
		.gg_clear (gg_clear)
	);

endmodule

//--- design/cart_pkg.sv
package cart_pkg;

	localparam int ADDR_W = 25; // Download byte address width

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [15:0]       word_t;
	typedef logic [1:0]        region_t;
	typedef logic [1:0]        region_prio_t; // 0 US>EU>JP, 1 EU>US>JP, 2 US>JP>EU, 3 JP>US>EU
	typedef logic [2:0]        eeprom_map_t;
	typedef logic [7:0]        sensor_delay_t;
	typedef logic [63:0]       serial_t;  // ASCII, first character in the top byte
	typedef logic [127:0]      gg_code_t; // Flags, address, compare, replace

	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	localparam sensor_delay_t SENSOR_DELAY_DEF = 8'd44;

	//////////////////////////////////////////////////////////////////////
	// Cartridge header offsets
	localparam int unsigned HDR_SERIAL_0 = 'h180;
	localparam int unsigned HDR_SERIAL_1 = 'h182;
	localparam int unsigned HDR_SERIAL_2 = 'h184;
	localparam int unsigned HDR_SERIAL_3 = 'h186;
	localparam int unsigned HDR_SERIAL_4 = 'h188;
	localparam int unsigned HDR_SERIAL_5 = 'h18A;
	localparam int unsigned HDR_CRC      = 'h18E;
	localparam int unsigned HDR_DECIDE   = 'h190; // Serial and checksum complete here
	localparam int unsigned HDR_REGION_0 = 'h1F0;
	localparam int unsigned HDR_REGION_1 = 'h1F2;
	localparam int unsigned HDR_READY    = 'h200;

	//////////////////////////////////////////////////////////////////////
	// Per-game quirks
	typedef struct packed {
		serial_t       serial;
		logic [15:0]   crc;         // Zero matches any checksum
		logic          bank_eeprom;
		eeprom_map_t   eeprom_map;
		logic          noram;
		logic          fmbusy;
		logic          gun_type;
		sensor_delay_t gun_delay;
	} quirk_entry_t;

	localparam int QUIRK_N = 8;

	localparam quirk_entry_t QUIRK_NONE = '{gun_delay: SENSOR_DELAY_DEF, default: '0};

	localparam quirk_entry_t QUIRK_TABLE [QUIRK_N] = '{
		'{"T-081276", 16'h0000, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0, 8'd44},  // Banked EEPROM
		'{"T-50446 ", 16'h0000, 1'b0, 3'd1, 1'b0, 1'b0, 1'b0, 8'd44},
		'{"MK-1215 ", 16'h0000, 1'b0, 3'd2, 1'b0, 1'b0, 1'b0, 8'd44},
		'{"T-081326", 16'h0000, 1'b0, 3'd3, 1'b0, 1'b0, 1'b0, 8'd44},
		'{"T-113016", 16'h0000, 1'b0, 3'd0, 1'b1, 1'b0, 1'b0, 8'd44},  // Fake RAM check
		'{"T-35036 ", 16'h0000, 1'b0, 3'd0, 1'b0, 1'b1, 1'b0, 8'd44},
		'{"T-95096-", 16'h0000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1, 8'd52},  // Justifier
		'{"MK-1533 ", 16'h0000, 1'b0, 3'd0, 1'b0, 1'b0, 1'b0, 8'd100}  // Menacer
	};

	typedef enum logic [1:0] {LD_IDLE, LD_CART, LD_CODE} ld_state_t;

endpackage

//--- design/cart_quirks.sv
module cart_quirks import cart_pkg::*; #(
	parameter int ADDR_W = cart_pkg::ADDR_W
) (
	input  logic          clk_sys,
	input  logic          RESET,
	load_if.sink          ld,
	output eeprom_map_t   eeprom_map,
	output logic          bank_eeprom_quirk,
	output logic          noram_quirk,
	output logic          fmbusy_quirk,
	output logic          gun_type,
	output sensor_delay_t gun_sensor_delay
);

	serial_t      cart_id; // Header bytes 0x183 to 0x18A
	logic [15:0]  crc;
	word_t        swapped;
	logic         hdr_wr;
	logic         found;
	quirk_entry_t sel;

	assign swapped = {ld.data[7:0], ld.data[15:8]}; // Even byte first
	assign hdr_wr  = ld.wr && ld.cart_load;

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (ld.addr == ADDR_W'(HDR_SERIAL_1)) cart_id[63:56] <= ld.data[15:8];
			if (ld.addr == ADDR_W'(HDR_SERIAL_2)) cart_id[55:40] <= swapped;
			if (ld.addr == ADDR_W'(HDR_SERIAL_3)) cart_id[39:24] <= swapped;
			if (ld.addr == ADDR_W'(HDR_SERIAL_4)) cart_id[23:8]  <= swapped;
			if (ld.addr == ADDR_W'(HDR_SERIAL_5)) cart_id[7:0]   <= ld.data[7:0];
			if (ld.addr == ADDR_W'(HDR_CRC))      crc            <= swapped;
		end
	end

	// First table hit wins
	always_comb begin
		found = 1'b0;
		sel   = QUIRK_NONE;
		for (int i = 0; i < QUIRK_N; i++) begin
			if (!found && cart_id == QUIRK_TABLE[i].serial &&
				(QUIRK_TABLE[i].crc == 16'h0000 || QUIRK_TABLE[i].crc == crc)) begin
				found = 1'b1;
				sel   = QUIRK_TABLE[i];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			eeprom_map        <= '0;
			bank_eeprom_quirk <= 1'b0;
			noram_quirk       <= 1'b0;
			fmbusy_quirk      <= 1'b0;
			gun_type          <= 1'b0;
			gun_sensor_delay  <= SENSOR_DELAY_DEF;
		end else begin
			if (ld.load_start) begin
				eeprom_map        <= '0;
				bank_eeprom_quirk <= 1'b0;
				noram_quirk       <= 1'b0;
				fmbusy_quirk      <= 1'b0;
			end
			if (hdr_wr && ld.addr == ADDR_W'(HDR_DECIDE)) begin
				eeprom_map        <= sel.eeprom_map;
				bank_eeprom_quirk <= sel.bank_eeprom;
				noram_quirk       <= sel.noram;
				fmbusy_quirk      <= sel.fmbusy;
				gun_type          <= sel.gun_type;  // Type 0 with no match
				gun_sensor_delay  <= sel.gun_delay; // 44 with no match
			end
		end
	end

endmodule

//--- design/cheat_loader.sv
module cheat_loader import cart_pkg::*; (
	input  logic     clk_sys,
	input  logic     RESET,
	load_if.sink     ld,
	output gg_code_t gg_code,
	output logic     gg_valid,
	output logic     gg_clear
);

	logic code_wr;
	logic code_done; // Last word of a record landed

	assign code_wr = ld.wr && ld.code_load;

	// Words arrive bottom half first, fields in big endian order
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ld.addr[3:0])
				4'd0:  gg_code[111:96]  <= ld.data; // Flags
				4'd2:  gg_code[127:112] <= ld.data;
				4'd4:  gg_code[79:64]   <= ld.data; // Address
				4'd6:  gg_code[95:80]   <= ld.data;
				4'd8:  gg_code[47:32]   <= ld.data; // Compare
				4'd10: gg_code[63:48]   <= ld.data;
				4'd12: gg_code[15:0]    <= ld.data; // Replace
				4'd14: gg_code[31:16]   <= ld.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_done <= 1'b0;
			gg_valid  <= 1'b0;
			gg_clear  <= 1'b0;
		end else begin
			code_done <= code_wr && ld.addr[3:0] == 4'd14;
			gg_valid  <= code_done && !gg_code[95]; // Bit 95 marks a disabled code
			gg_clear  <= code_wr && ld.addr == '0;
		end
	end

endmodule

//--- design/load_ctrl.sv
module load_ctrl import cart_pkg::*; #(
	parameter int ADDR_W = cart_pkg::ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic              ioctl_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  word_t             ioctl_data,
	input  logic              auto_region_off,
	input  region_t           region_choice,
	load_if.ctrl              ld,
	output region_t           region_req,
	output logic              region_set,
	output logic [ADDR_W-1:0] rom_size
);

	ld_state_t state;
	logic      code_index;
	logic      hdr_ready;
	logic      hdr_ready_q;

	assign code_index = &ioctl_index; // Index FF carries cheat codes

	assign ld.cart_load = (state == LD_CART);
	assign ld.code_load = (state == LD_CODE);

	//////////////////////////////////////////////////////////////////////
	// Download FSM and stream register
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state         <= LD_IDLE;
			ld.wr         <= 1'b0;
			ld.load_start <= 1'b0;
			ld.load_end   <= 1'b0;
		end else begin
			ld.wr         <= ioctl_wr;
			ld.load_start <= (state == LD_IDLE) && ioctl_download && !code_index;
			ld.load_end   <= (state == LD_CART) && !ioctl_download;
			case (state)
				LD_IDLE: if (ioctl_download) state <= code_index ? LD_CODE : LD_CART;
				default: if (!ioctl_download) state <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			ld.addr <= ioctl_addr;
			ld.data <= ioctl_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Header ready, region request and ROM size
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_ready   <= 1'b0;
			hdr_ready_q <= 1'b0;
			region_set  <= 1'b0;
			region_req  <= REGION_JP;
			rom_size    <= '0;
		end else begin
			hdr_ready_q <= hdr_ready;
			if (ld.wr && ld.cart_load && ld.addr == ADDR_W'(HDR_READY))
				hdr_ready <= 1'b1;

			// Region flags are settled by the time ready rises
			if (hdr_ready && !hdr_ready_q && !auto_region_off) begin
				region_set <= 1'b1;
				region_req <= region_choice;
			end

			if (ld.load_end) begin
				hdr_ready  <= 1'b0;
				region_set <= 1'b0;
				rom_size   <= ld.addr; // Last written address
			end
		end
	end

endmodule

//--- design/load_if.sv
interface load_if import cart_pkg::*; #(
	parameter int ADDR_W = cart_pkg::ADDR_W
) ();

	logic              wr;         // Write seen one cycle earlier
	logic [ADDR_W-1:0] addr;       // Held from the last write
	word_t             data;
	logic              cart_load;
	logic              code_load;
	logic              load_start; // Cartridge download only
	logic              load_end;

	modport ctrl (output wr, addr, data, cart_load, code_load, load_start, load_end);

	modport sink (input wr, addr, data, cart_load, code_load, load_start, load_end);

endinterface

//--- design/region_detect.sv
module region_detect import cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	load_if.sink         ld,
	input  region_prio_t region_priority,
	output region_t      region_choice
);

	logic       hdr_j;
	logic       hdr_u;
	logic       hdr_e;
	logic [7:0] lo;
	logic [7:0] hi;
	logic [3:0] hrgn;

	assign lo   = ld.data[7:0];
	assign hi   = ld.data[15:8];
	assign hrgn = lo[3:0] - 4'd7; // 'A'..'F' give 10..15

	//////////////////////////////////////////////////////////////////////
	// Header region flags
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
		end else begin
			if (ld.load_start)
				{hdr_j, hdr_u, hdr_e} <= 3'b000;

			if (ld.wr && ld.cart_load) begin
				if (ld.addr == HDR_REGION_0) begin
					if (lo == "J") hdr_j <= 1'b1;
					else if (lo == "U") hdr_u <= 1'b1;
					else if (lo == "E") hdr_e <= 1'b1;
					else if (lo >= "0" && lo <= "9")
						{hdr_e, hdr_u, hdr_j} <= {lo[3], lo[2], lo[0]}; // New style code
					else if (lo >= "A" && lo <= "F")
						{hdr_e, hdr_u, hdr_j} <= {hrgn[3], hrgn[2], hrgn[0]};

					// Second letter of the old style string
					if (hi == "J") hdr_j <= 1'b1;
					else if (hi == "U") hdr_u <= 1'b1;
					else if (hi == "E") hdr_e <= 1'b1;
				end

				if (ld.addr == HDR_REGION_1) begin
					if (lo == "J") hdr_j <= 1'b1;
					else if (lo == "U") hdr_u <= 1'b1;
					else if (lo == "E") hdr_e <= 1'b1;
				end
			end
		end
	end

	// First flagged region in priority order, else the order's head
	always_comb begin
		case (region_priority)
			2'd0: region_choice = hdr_u ? REGION_US : hdr_e ? REGION_EU :
				hdr_j ? REGION_JP : REGION_US;
			2'd1: region_choice = hdr_e ? REGION_EU : hdr_u ? REGION_US :
				hdr_j ? REGION_JP : REGION_EU;
			2'd2: region_choice = hdr_u ? REGION_US : hdr_j ? REGION_JP :
				hdr_e ? REGION_EU : REGION_US;
			default: region_choice = hdr_j ? REGION_JP : hdr_u ? REGION_US :
				hdr_e ? REGION_EU : REGION_JP;
		endcase
	end

endmodule

//--- sim.f
+incdir+sim
design/cart_pkg.sv
design/load_if.sv
design/load_ctrl.sv
design/region_detect.sv
design/cart_quirks.sv
design/cheat_loader.sv
design/cart_loader_top.sv
sim/tb_cart_loader.sv

//--- sim/cart_model.svh
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

// One flag bit per region code, indexed by region_t
function automatic logic [2:0] letter_mask(logic [7:0] c);
	case (c)
		"J":     return 3'b001;
		"U":     return 3'b010;
		"E":     return 3'b100;
		default: return 3'b000;
	endcase
endfunction

function automatic region_t model_region(logic [7:0] lo0, logic [7:0] hi0, logic [7:0] lo1,
		region_prio_t prio);
	logic [2:0] flags;
	logic [7:0] v;
	logic [5:0] order; // Head of the list in the top bits
	region_t    r;

	flags = letter_mask(lo0);
	if (flags == 3'b000 && lo0 >= "0" && lo0 <= "9") begin
		v     = lo0 - 8'h30;
		flags = {v[3], v[2], v[0]};
	end else if (flags == 3'b000 && lo0 >= "A" && lo0 <= "F") begin
		v     = lo0 - 8'h37; // 'A' counts as ten
		flags = {v[3], v[2], v[0]};
	end
	flags = flags | letter_mask(hi0) | letter_mask(lo1);

	case (prio)
		2'd0:    order = {REGION_US, REGION_EU, REGION_JP};
		2'd1:    order = {REGION_EU, REGION_US, REGION_JP};
		2'd2:    order = {REGION_US, REGION_JP, REGION_EU};
		default: order = {REGION_JP, REGION_US, REGION_EU};
	endcase
	r = order[5:4]; // Fallback
	for (int k = 0; k < 3; k++)
		if (flags[order[2*k +: 2]])
			r = order[2*k +: 2];
	return r;
endfunction

function automatic quirk_entry_t model_quirk(serial_t s, logic [15:0] crc);
	quirk_entry_t q;

	q           = '0;
	q.gun_delay = 8'd44;
	// Walk backwards so the earliest match is left standing
	for (int i = QUIRK_N - 1; i >= 0; i--)
		if (s == QUIRK_TABLE[i].serial && (QUIRK_TABLE[i].crc == 16'h0000 ||
				QUIRK_TABLE[i].crc == crc))
			q = QUIRK_TABLE[i];
	return q;
endfunction

// Word at offset 2i sits in words[16*i +: 16]
function automatic gg_code_t model_pack(logic [127:0] words);
	logic [31:0] flags;
	logic [31:0] addr;
	logic [31:0] cmp;
	logic [31:0] rep;

	flags = {words[31:16], words[15:0]};
	addr  = {words[63:48], words[47:32]};
	cmp   = {words[95:80], words[79:64]};
	rep   = {words[127:112], words[111:96]};
	return {flags, addr, cmp, rep};
endfunction

`endif

//--- sim/tb_cart_loader.sv
module tb_cart_loader import cart_pkg::*; ();

	localparam int N_CART       = 24;
	localparam int N_CODE       = 16;
	localparam int WATCH_CYCLES = 200 * (N_CART + N_CODE) + 1000;

	logic          clk_sys;
	logic          RESET;
	logic          ioctl_download;
	logic [7:0]    ioctl_index;
	logic          ioctl_wr;
	addr_t         ioctl_addr;
	word_t         ioctl_data;
	logic          auto_region_off;
	region_prio_t  region_priority;
	region_t       region_req;
	logic          region_set;
	addr_t         rom_size;
	eeprom_map_t   eeprom_map;
	logic          bank_eeprom_quirk;
	logic          noram_quirk;
	logic          fmbusy_quirk;
	logic          gun_type;
	sensor_delay_t gun_sensor_delay;
	gg_code_t      gg_code;
	logic          gg_valid;
	logic          gg_clear;

	logic [31:0]   rng_state;
	int            set_cnt = 0;
	int            valid_cnt = 0;
	int            clear_cnt = 0;

	`include "cart_model.svh"

	cart_loader_top #(.ADDR_W(ADDR_W)) u_cart_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Output activity, sampled away from the active edge
	always @(negedge clk_sys) begin
		if (region_set) set_cnt++;
		if (gg_valid) valid_cnt++;
		if (gg_clear) clear_cnt++;
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic [7:0] random_region_byte();
		logic [31:0] r;

		r = next_rand();
		case (r[1:0])
			2'd0:    return (r[9:8] == 2'd0) ? "J" : (r[9:8] == 2'd1) ? "U" : "E";
			2'd1:    return 8'h30 + 8'(r[15:8] % 10); // Digit
			2'd2:    return 8'h41 + 8'(r[15:8] % 6);  // Hex letter
			default: return r[23:16];
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compares
	task automatic fail_run(string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic report_error(string msg);
		fail_run($sformatf("Error at time %0t: %s", $time, msg));
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_count(int got, int exp, string what);
		if (got != exp) report_error($sformatf("%0d %s, expected %0d", got, what, exp));
	endtask

	task automatic check_region(region_t got, region_t exp);
		if (got !== exp) report_error($sformatf("region_req %0d, expected %0d", got, exp));
	endtask

	task automatic check_quirks(eeprom_map_t got_map, eeprom_map_t exp_map,
			logic [3:0] got_flags, logic [3:0] exp_flags);
		if (got_map !== exp_map)
			report_error($sformatf("eeprom_map %0d, expected %0d", got_map, exp_map));
		else if (got_flags !== exp_flags)
			report_error($sformatf("bank/noram/fmbusy/gun %b, expected %b", got_flags, exp_flags));
	endtask

	task automatic check_sensor(sensor_delay_t got, sensor_delay_t exp);
		if (got !== exp) report_error($sformatf("gun_sensor_delay %0d, expected %0d", got, exp));
	endtask

	task automatic check_code(gg_code_t got, gg_code_t exp);
		if (got !== exp) report_error($sformatf("gg_code %h, expected %h", got, exp));
	endtask

	task automatic check_size(addr_t got, addr_t exp);
		if (got !== exp) report_error($sformatf("rom_size %h, expected %h", got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Download stimulus
	task automatic idle_cycle();
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic write_word(addr_t a, word_t d);
		@(negedge clk_sys);
		ioctl_wr   = 1'b1;
		ioctl_addr = a;
		ioctl_data = d;
		if (next_rand() % 3 == 0) idle_cycle(); // Otherwise back to back
	endtask

	task automatic start_download(logic [7:0] index);
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		idle_cycle();
	endtask

	task automatic end_download();
		idle_cycle();
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys); // End pulse, then the registers behind it
	endtask

	task automatic wait_region_set();
		int n;

		n = 0;
		while (!region_set && n < 10) begin
			idle_cycle();
			n++;
		end
		if (!region_set) fail_run("region_set did not rise after the header-ready write");
	endtask

	task automatic run_cart();
		logic [7:0]   hdr [16]; // Bytes 0x180 to 0x18F
		serial_t      serial;
		logic [7:0]   lo0;
		logic [7:0]   hi0;
		logic [7:0]   lo1;
		logic         auto_off;
		region_prio_t prio;
		quirk_entry_t q;
		int           base_set;
		int           n_tail;
		addr_t        last;

		if (next_rand() % 2 == 0)
			serial = QUIRK_TABLE[next_rand() % QUIRK_N].serial;
		else
			for (int k = 0; k < 8; k++)
				serial[8*k +: 8] = 8'h20 + 8'(next_rand() % 95);
		for (int k = 0; k < 16; k++)
			hdr[k] = 8'(next_rand());
		for (int k = 0; k < 8; k++)
			hdr[3 + k] = serial[63 - 8*k -: 8]; // Serial text at 0x183
		lo0      = random_region_byte();
		hi0      = random_region_byte();
		lo1      = random_region_byte();
		prio     = region_prio_t'(next_rand() % 4);
		auto_off = (next_rand() % 4 == 0);

		@(negedge clk_sys);
		region_priority = prio;
		auto_region_off = auto_off;
		base_set        = set_cnt;
		start_download(8'(next_rand() % 128));
		for (int k = 0; k < 16; k += 2)
			write_word(addr_t'(HDR_SERIAL_0 + k), {hdr[k + 1], hdr[k]});
		write_word(addr_t'(HDR_DECIDE), word_t'(next_rand()));
		write_word(addr_t'(HDR_REGION_0), {hi0, lo0});
		write_word(addr_t'(HDR_REGION_1), {8'(next_rand()), lo1});
		write_word(addr_t'(HDR_READY), word_t'(next_rand()));
		if (!auto_off) begin
			wait_region_set();
			check_region(region_req, model_region(lo0, hi0, lo1, prio));
		end
		n_tail = 1 + next_rand() % 6;
		for (int k = 0; k < n_tail; k++)
			write_word(addr_t'(HDR_READY + 2 + 2*k), word_t'(next_rand()));
		last = addr_t'(32'h400 + (next_rand() & 32'h0FF_FFFE));
		write_word(last, word_t'(next_rand()));
		end_download();

		check_flag(region_set, 1'b0, "region_set after the download");
		check_size(rom_size, last);
		if (auto_off) check_count(set_cnt - base_set, 0, "region_set cycles with auto region off");
		q = model_quirk(serial, {hdr[14], hdr[15]});
		check_quirks(eeprom_map, q.eeprom_map,
			{bank_eeprom_quirk, noram_quirk, fmbusy_quirk, gun_type},
			{q.bank_eeprom, q.noram, q.fmbusy, q.gun_type});
		check_sensor(gun_sensor_delay, q.gun_delay);
	endtask

	task automatic run_code();
		logic [127:0] words;
		addr_t        base;
		int           base_valid;
		int           base_clear;
		gg_code_t     exp;

		for (int k = 0; k < 4; k++)
			words[32*k +: 32] = next_rand();
		base = (next_rand() % 3 == 0) ? '0 : addr_t'((next_rand() % 4096) << 4);
		base_valid = valid_cnt;
		base_clear = clear_cnt;
		start_download(8'hFF);
		for (int k = 0; k < 8; k++)
			write_word(base + addr_t'(2*k), words[16*k +: 16]);
		end_download();

		exp = model_pack(words);
		check_code(gg_code, exp);
		check_count(valid_cnt - base_valid, exp[95] ? 0 : 1, "gg_valid pulses");
		check_count(clear_cnt - base_clear, (base == '0) ? 1 : 0, "gg_clear pulses");
	endtask

	//////////////////////////////////////////////////////////////////////
	initial begin
		rng_state       = 32'd77464;
		RESET           = 1'b1;
		ioctl_download  = 1'b0;
		ioctl_index     = 8'h00;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		auto_region_off = 1'b0;
		region_priority = 2'd0;
		repeat (16) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		check_flag(region_set, 1'b0, "region_set after reset");
		check_flag(gg_valid, 1'b0, "gg_valid after reset");
		check_flag(gg_clear, 1'b0, "gg_clear after reset");
		check_quirks(eeprom_map, 3'd0,
			{bank_eeprom_quirk, noram_quirk, fmbusy_quirk, gun_type}, 4'b0000);
		check_sensor(gun_sensor_delay, 8'd44);
		check_size(rom_size, '0);

		for (int i = 0; i < N_CART + N_CODE; i++) begin
			if (i % 5 < 3) run_cart();
			else run_code();
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk_sys);
		fail_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
			WATCH_CYCLES));
	end

endmodule
